// File: include/video_config.svh
// Raster geometry and tile layer constants for the tile video subsystem
// Small raster so that whole frames simulate quickly

`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Horizontal raster, in pixels
`define H_TOTAL         64
`define H_VISIBLE       48
`define HS_START        52
`define HS_END          56

// Vertical raster, in lines
`define V_TOTAL         40
`define V_VISIBLE       32
`define VS_START        34
`define VS_END          36

// Tile map is MAP_COLS x MAP_COLS tiles of 8x8 pixels
`define MAP_COLS        32

// 48 visible pixels plus up to 7 pixels of fine scroll
`define LINE_TILES      7

// Colour code that lets the backdrop through
`define TRANSPARENT_PEN 15

`endif

// File: verilog/video_pkg.sv
// Shared types for the tile video subsystem
// Raster bundle, CPU registers, colours and FSM encodings

`default_nettype none

package video_pkg;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic [8:0] vrender;   // line being fetched
        logic       hb;
        logic       vb;
        logic       hs;
        logic       vs;
        logic       start;
    } raster_t;

    typedef struct packed {
        logic [9:0] hpos;
        logic [9:0] vpos;
        logic [7:0] vram_base;
        rgb_t       backdrop;
        logic       layer_en;
        logic       spare;
    } mmr_regs_t;

    typedef struct packed {
        logic       we;
        logic [5:0] index;
        rgb_t       color;
    } pal_wr_t;

    typedef struct packed {
        logic [1:0] pal;
        logic [3:0] color;
    } tile_pxl_t;

    // Word addresses seen on addr[4:1]
    typedef enum logic [3:0] {
        HPOS      = 4'd0,
        VPOS      = 4'd1,
        VRAM_BASE = 4'd2,
        BACKDROP  = 4'd3,
        LAYER_EN  = 4'd4,
        PAL_INDEX = 4'd5,
        PAL_DATA  = 4'd6
    } mmr_reg_e;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        MAP_REQ = 2'd1,
        ROM_REQ = 2'd2,
        STORE   = 2'd3
    } fetch_state_e;

endpackage

`default_nettype wire

// File: verilog/video_timing.sv
// Raster timing generator
// Horizontal and vertical counters stepped by the pixel clock enable,
// with sync, blank and line start decoded from the counters

`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module video_timing (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 pxl_cen,
    output video_pkg::raster_t  raster
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (hcnt == `H_TOTAL - 1) begin
                hcnt <= '0;
                vcnt <= (vcnt == `V_TOTAL - 1) ? 9'd0 : vcnt + 9'd1;
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    always_comb begin
        raster.hdump   = hcnt;
        raster.vdump   = vcnt;
        // Next line, fetched one line ahead of display
        raster.vrender = (vcnt == `V_TOTAL - 1) ? 9'd0 : vcnt + 9'd1;
        raster.hb      = hcnt >= `H_VISIBLE;
        raster.vb      = vcnt >= `V_VISIBLE;
        raster.hs      = (hcnt >= `HS_START) && (hcnt < `HS_END);
        raster.vs      = (vcnt >= `VS_START) && (vcnt < `VS_END);
        raster.start   = hcnt == 9'd0;
    end

endmodule

`default_nettype wire

// File: verilog/video_mmr.sv
// CPU register block for the video subsystem
// Scroll, map base, backdrop and layer enable with byte lane writes,
// plus an auto-incrementing palette index/data port

`timescale 1ns/1ps
`default_nettype none

module video_mmr (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   cpu_cs,
    input  wire  [4:1]            addr,
    input  wire  [1:0]            dsn,
    input  wire  [15:0]           cpu_dout,
    output logic [15:0]           mmr_dout,
    output video_pkg::mmr_regs_t  regs,
    output video_pkg::pal_wr_t    pal_wr
);

    logic [5:0]  pal_index;
    logic [11:0] pal_data;
    logic [15:0] wr_word;

    // dsn is active low, one bit per byte
    function automatic logic [15:0] lane_merge(
        input logic [15:0] old_val,
        input logic [15:0] new_val,
        input logic [1:0]  lanes_n
    );
        logic [15:0] merged;
        merged = old_val;
        if (!lanes_n[1]) merged[15:8] = new_val[15:8];
        if (!lanes_n[0]) merged[7:0] = new_val[7:0];
        return merged;
    endfunction

    always_comb begin
        case (video_pkg::mmr_reg_e'(addr))
            video_pkg::HPOS:      mmr_dout = {6'd0, regs.hpos};
            video_pkg::VPOS:      mmr_dout = {6'd0, regs.vpos};
            video_pkg::VRAM_BASE: mmr_dout = {8'd0, regs.vram_base};
            video_pkg::BACKDROP:  mmr_dout = {4'd0, regs.backdrop};
            video_pkg::LAYER_EN:  mmr_dout = {15'd0, regs.layer_en};
            video_pkg::PAL_INDEX: mmr_dout = {10'd0, pal_index};
            video_pkg::PAL_DATA:  mmr_dout = {4'd0, pal_data};
            default:              mmr_dout = 16'd0;
        endcase
    end

    // Readback of the target register doubles as the old value for merging
    assign wr_word = lane_merge(mmr_dout, cpu_dout, dsn);

    always_ff @(posedge clk) begin
        if (reset) begin
            regs      <= '0;
            pal_index <= '0;
            pal_data  <= '0;
            pal_wr    <= '0;
        end else begin
            pal_wr.we <= 1'b0;
            if (cpu_cs) begin
                case (video_pkg::mmr_reg_e'(addr))
                    video_pkg::HPOS:      regs.hpos <= wr_word[9:0];
                    video_pkg::VPOS:      regs.vpos <= wr_word[9:0];
                    video_pkg::VRAM_BASE: regs.vram_base <= wr_word[7:0];
                    video_pkg::BACKDROP:  regs.backdrop <= video_pkg::rgb_t'(wr_word[11:0]);
                    video_pkg::LAYER_EN:  regs.layer_en <= wr_word[0];
                    video_pkg::PAL_INDEX: pal_index <= wr_word[5:0];
                    video_pkg::PAL_DATA: begin
                        pal_data     <= wr_word[11:0];
                        pal_wr.we    <= 1'b1;
                        pal_wr.index <= pal_index;
                        pal_wr.color <= video_pkg::rgb_t'(wr_word[11:0]);
                        // Wraps at 64 entries
                        pal_index    <= pal_index + 6'd1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/tile_scroll.sv
// Tile scroll layer
// Fetches map words and 8x8 tile rows one line ahead of display into
// a double line buffer, then shifts out one pixel per pixel clock

`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module tile_scroll (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   pxl_cen,
    input  wire video_pkg::raster_t   raster,
    input  wire video_pkg::mmr_regs_t regs,
    output logic [17:0]           vram_addr,
    input  wire  [15:0]           vram_data,
    output logic                  vram_cs,
    input  wire                   vram_ok,
    output logic [14:0]           rom_addr,
    input  wire  [31:0]           rom_data,
    output logic                  rom_cs,
    input  wire                   rom_ok,
    output video_pkg::tile_pxl_t  pxl
);

    video_pkg::fetch_state_e state;
    video_pkg::tile_pxl_t    line_buf [0:1][0:55];

    logic        wr_bank;
    logic        rd_bank;
    logic [2:0]  fetch_fine;
    logic [2:0]  disp_fine;
    logic [2:0]  rd_fine;
    logic [5:0]  rd_idx;
    logic [7:0]  base_q;
    logic [7:0]  row_q;
    logic [4:0]  col_q;
    logic [2:0]  tile_cnt;
    logic [2:0]  pix_cnt;
    logic [11:0] code_q;
    logic [1:0]  pal_q;
    logic        hflip_q;
    logic [31:0] pix_data;
    logic [2:0]  nib_sel;

    assign vram_cs   = state == video_pkg::MAP_REQ;
    assign rom_cs    = state == video_pkg::ROM_REQ;
    assign vram_addr = {base_q, row_q[7:3], col_q};
    assign rom_addr  = {code_q, row_q[2:0]};

    // Leftmost pixel sits in the top nibble unless flipped
    assign nib_sel = hflip_q ? pix_cnt : ~pix_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= video_pkg::IDLE;
            wr_bank    <= 1'b0;
            fetch_fine <= '0;
            disp_fine  <= '0;
            tile_cnt   <= '0;
            pix_cnt    <= '0;
        end else if (raster.start && pxl_cen) begin
            // Swap buffers and latch scroll for the next line
            wr_bank    <= ~wr_bank;
            disp_fine  <= fetch_fine;
            fetch_fine <= regs.hpos[2:0];
            base_q     <= regs.vram_base;
            row_q      <= raster.vrender[7:0] + regs.vpos[7:0];
            col_q      <= regs.hpos[7:3];
            tile_cnt   <= '0;
            state      <= video_pkg::MAP_REQ;
        end else begin
            case (state)
                video_pkg::MAP_REQ: if (vram_ok) begin
                    code_q  <= vram_data[11:0];
                    pal_q   <= vram_data[13:12];
                    hflip_q <= vram_data[14];
                    state   <= video_pkg::ROM_REQ;
                end
                video_pkg::ROM_REQ: if (rom_ok) begin
                    pix_data <= rom_data;
                    pix_cnt  <= '0;
                    state    <= video_pkg::STORE;
                end
                video_pkg::STORE: begin
                    pix_cnt <= pix_cnt + 3'd1;
                    if (pix_cnt == 3'd7) begin
                        if (tile_cnt == `LINE_TILES - 1) begin
                            state <= video_pkg::IDLE;
                        end else begin
                            tile_cnt <= tile_cnt + 3'd1;
                            // Map wraps horizontally
                            col_q    <= (col_q == `MAP_COLS - 1) ? 5'd0 : col_q + 5'd1;
                            state    <= video_pkg::MAP_REQ;
                        end
                    end
                end
                default: state <= video_pkg::IDLE;
            endcase
        end
    end

    // One buffer slot per clk while storing
    always_ff @(posedge clk) begin
        if (state == video_pkg::STORE) begin
            line_buf[wr_bank][{tile_cnt, pix_cnt}] <= '{
                pal:   pal_q,
                color: pix_data[{nib_sel, 2'b00} +: 4]
            };
        end
    end

    // At line start the swap has not landed yet, so look ahead
    assign rd_bank = raster.start ? wr_bank : ~wr_bank;
    assign rd_fine = raster.start ? fetch_fine : disp_fine;
    assign rd_idx  = raster.hdump[5:0] + {3'd0, rd_fine};

    always_ff @(posedge clk) begin
        if (reset) begin
            pxl <= '0;
        end else if (pxl_cen && !raster.hb) begin
            pxl <= line_buf[rd_bank][rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/layer_mix.sv
// Colour mixer
// Palette RAM lookup, backdrop on transparency or disabled layer,
// blanking and 4 to 8 bit colour expansion

`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module layer_mix (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       pxl_cen,
    input  wire video_pkg::raster_t   raster,
    input  wire video_pkg::mmr_regs_t regs,
    input  wire video_pkg::pal_wr_t   pal_wr,
    input  wire video_pkg::tile_pxl_t pxl,
    output logic [7:0]                red,
    output logic [7:0]                green,
    output logic [7:0]                blue,
    output logic                      lhbl_dly,
    output logic                      lvbl_dly
);

    video_pkg::rgb_t pal_ram [0:63];
    video_pkg::rgb_t mix_rgb;
    video_pkg::rgb_t rgb_q;

    // Blanks for the pixel currently on pxl
    logic hb_d;
    logic vb_d;

    // Palette starts out black
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                pal_ram[i] <= '0;
            end
        end else if (pal_wr.we) begin
            pal_ram[pal_wr.index] <= pal_wr.color;
        end
    end

    always_comb begin
        if (hb_d || vb_d) begin
            mix_rgb = '0;
        end else if (!regs.layer_en || pxl.color == `TRANSPARENT_PEN) begin
            mix_rgb = regs.backdrop;
        end else begin
            // Entry is pal * 16 + colour
            mix_rgb = pal_ram[{pxl.pal, pxl.color}];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hb_d     <= 1'b0;
            vb_d     <= 1'b0;
            rgb_q    <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
        end else if (pxl_cen) begin
            hb_d     <= raster.hb;
            vb_d     <= raster.vb;
            rgb_q    <= mix_rgb;
            lhbl_dly <= ~hb_d;
            lvbl_dly <= ~vb_d;
        end
    end

    // Nibble repeated so full scale maps to 8'hff
    assign red   = {rgb_q.r, rgb_q.r};
    assign green = {rgb_q.g, rgb_q.g};
    assign blue  = {rgb_q.b, rgb_q.b};

endmodule

`default_nettype wire

// File: verilog/video_top.sv
// Tile video subsystem top level
// Raster timing, CPU registers, one scroll layer and the colour mixer

`timescale 1ns/1ps
`default_nettype none

module video_top (
    input  wire         clk,
    input  wire         reset,
    input  wire         pxl_cen,

    // CPU interface
    input  wire         cpu_cs,
    input  wire  [4:1]  addr,
    input  wire  [1:0]  dsn,
    input  wire  [15:0] cpu_dout,
    output wire  [15:0] mmr_dout,

    // Video RAM
    output wire  [17:0] vram_addr,
    input  wire  [15:0] vram_data,
    output wire         vram_cs,
    input  wire         vram_ok,

    // Graphics ROM
    output wire  [14:0] rom_addr,
    input  wire  [31:0] rom_data,
    output wire         rom_cs,
    input  wire         rom_ok,

    // Video out
    output wire  [8:0]  hdump,
    output wire  [8:0]  vdump,
    output wire         hs,
    output wire         vs,
    output wire         hb,
    output wire         vb,
    output wire         lhbl_dly,
    output wire         lvbl_dly,
    output wire  [7:0]  red,
    output wire  [7:0]  green,
    output wire  [7:0]  blue
);

    wire video_pkg::raster_t   raster;
    wire video_pkg::mmr_regs_t regs;
    wire video_pkg::pal_wr_t   pal_wr;
    wire video_pkg::tile_pxl_t scr_pxl;

    assign hdump = raster.hdump;
    assign vdump = raster.vdump;
    assign hs    = raster.hs;
    assign vs    = raster.vs;
    assign hb    = raster.hb;
    assign vb    = raster.vb;

    video_timing u_timing (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .raster   ( raster   )
    );

    video_mmr u_mmr (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cpu_cs   ( cpu_cs   ),
        .addr     ( addr     ),
        .dsn      ( dsn      ),
        .cpu_dout ( cpu_dout ),
        .mmr_dout ( mmr_dout ),
        .regs     ( regs     ),
        .pal_wr   ( pal_wr   )
    );

    tile_scroll u_scroll (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .raster    ( raster    ),
        .regs      ( regs      ),
        .vram_addr ( vram_addr ),
        .vram_data ( vram_data ),
        .vram_cs   ( vram_cs   ),
        .vram_ok   ( vram_ok   ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_cs    ( rom_cs    ),
        .rom_ok    ( rom_ok    ),
        .pxl       ( scr_pxl   )
    );

    layer_mix u_mix (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .raster   ( raster   ),
        .regs     ( regs     ),
        .pal_wr   ( pal_wr   ),
        .pxl      ( scr_pxl  ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

endmodule

`default_nettype wire

// File: verif/video_tb.sv
// Testbench for the tile video subsystem
// Memory models with random latency, CPU register traffic and a
// pixel by pixel comparison against a reference of the tile layer

`timescale 1ns/1ps
`default_nettype none

`include "video_config.svh"

module video_tb;

    localparam int FRAME_NS   = `H_TOTAL * `V_TOTAL * 4 * 4;
    // Frame waits of the raster, backdrop, scroll and mid-scroll tests plus three spare
    localparam int RUN_FRAMES = 2 + 3 + 3 + 3 + 3;

    logic        clk;
    logic        reset;
    logic        pxl_cen;
    logic        cpu_cs;
    logic [3:0]  addr;
    logic [1:0]  dsn;
    logic [15:0] cpu_dout;
    wire  [15:0] mmr_dout;
    wire  [17:0] vram_addr;
    logic [15:0] vram_data;
    wire         vram_cs;
    logic        vram_ok;
    wire  [14:0] rom_addr;
    logic [31:0] rom_data;
    wire         rom_cs;
    logic        rom_ok;
    wire  [8:0]  hdump;
    wire  [8:0]  vdump;
    wire         hs;
    wire         vs;
    wire         hb;
    wire         vb;
    wire         lhbl_dly;
    wire         lvbl_dly;
    wire  [7:0]  red;
    wire  [7:0]  green;
    wire  [7:0]  blue;

    logic [15:0] map_mem [0:262143];
    logic [31:0] rom_mem [0:32767];

    // CPU register model indexed by register address
    logic [15:0]     m_reg [0:6];
    video_pkg::rgb_t m_pal [0:63];

    // Scroll values latched per fetched line
    logic [15:0] sh_hpos [0:`V_TOTAL-1];
    logic [15:0] sh_vpos [0:`V_TOTAL-1];
    logic [15:0] sh_base [0:`V_TOTAL-1];

    logic [31:0] rng_main;
    logic [31:0] rng_vram;
    logic [31:0] rng_rom;
    logic [1:0]  vram_wait;
    logic [1:0]  rom_wait;
    logic [1:0]  cen_cnt;
    logic        check_on;
    string       test_name;
    int          rgb_errs;
    int          word_errs;
    int          bit_errs;
    int          other_errs;
    int          h1;
    int          v1;
    int          h2;
    int          v2;
    int          hist_n;

    video_top u_video_top (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen),
        .cpu_cs(cpu_cs), .addr(addr), .dsn(dsn), .cpu_dout(cpu_dout), .mmr_dout(mmr_dout),
        .vram_addr(vram_addr), .vram_data(vram_data), .vram_cs(vram_cs), .vram_ok(vram_ok),
        .rom_addr(rom_addr), .rom_data(rom_data), .rom_cs(rom_cs), .rom_ok(rom_ok),
        .hdump(hdump), .vdump(vdump), .hs(hs), .vs(vs), .hb(hb), .vb(vb),
        .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly), .red(red), .green(green), .blue(blue)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] reg_mask(input int a);
        case (a)
            0, 1:    return 16'h03ff;
            2:       return 16'h00ff;
            3, 6:    return 16'h0fff;
            4:       return 16'h0001;
            default: return 16'h003f;
        endcase
    endfunction

    // Expected colour of one pixel from the tile map rules
    function automatic video_pkg::rgb_t expected_rgb(input int h, input int v);
        int          px;
        int          py;
        int          col;
        logic [15:0] word;
        logic [31:0] row_bits;
        logic [3:0]  pen;
        if (h >= `H_VISIBLE || v >= `V_VISIBLE) return '0;
        if (!m_reg[4][0]) return video_pkg::rgb_t'(m_reg[3][11:0]);
        px = (int'(sh_hpos[v]) + h) & 255;
        py = (v + int'(sh_vpos[v])) & 255;
        word = map_mem[int'(sh_base[v][7:0]) * 1024 + (py / 8) * `MAP_COLS + px / 8];
        col = word[14] ? 7 - px % 8 : px % 8;
        row_bits = rom_mem[int'(word[11:0]) * 8 + py % 8];
        pen = row_bits[31 - 4 * col -: 4];
        if (pen == `TRANSPARENT_PEN) return video_pkg::rgb_t'(m_reg[3][11:0]);
        return m_pal[{word[13:12], pen}];
    endfunction

    task automatic check_rgb(input string name, input video_pkg::rgb_t exp,
                             input video_pkg::rgb_t act);
        if (exp !== act) begin
            rgb_errs++;
            $display("ERR %s expected %h actual %h (time %0t)", name, exp, act, $time);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            word_errs++;
            $display("ERR %s expected %h actual %h (time %0t)", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            bit_errs++;
            $display("ERR %s expected %b actual %b (time %0t)", name, exp, act, $time);
        end
    endtask

    task automatic cpu_write(input int a, input logic [15:0] d, input logic [1:0] lanes_n);
        logic [15:0] merged;
        @(negedge clk);
        cpu_cs   = 1'b1;
        addr     = a[3:0];
        dsn      = lanes_n;
        cpu_dout = d;
        @(negedge clk);
        cpu_cs = 1'b0;
        dsn    = 2'b11;
        merged = m_reg[a];
        if (!lanes_n[1]) merged[15:8] = d[15:8];
        if (!lanes_n[0]) merged[7:0] = d[7:0];
        merged = merged & reg_mask(a);
        if (a == 6) begin
            m_pal[m_reg[5][5:0]] = video_pkg::rgb_t'(merged[11:0]);
            m_reg[5] = (m_reg[5] + 16'd1) & 16'h003f;
        end
        m_reg[a] = merged;
    endtask

    task automatic read_check(input int a, input string name);
        @(negedge clk);
        addr = a[3:0];
        #0.5;
        check_word(name, m_reg[a], mmr_dout);
    endtask

    task automatic wait_frame_start();
        do @(negedge clk); while (!(vdump == 9'd0 && hdump == 9'd0));
        do @(negedge clk); while (hdump == 9'd0);
    endtask

    // Pixel clock enable once every four clk
    always @(negedge clk) begin
        cen_cnt = cen_cnt + 2'd1;
        pxl_cen = cen_cnt == 2'd3;
    end

    always @(negedge clk) begin
        if (vram_ok) begin
            vram_ok = 1'b0;
        end else if (vram_cs) begin
            if (vram_wait == 2'd0) begin
                vram_ok   = 1'b1;
                vram_data = map_mem[vram_addr];
            end else begin
                vram_wait = vram_wait - 2'd1;
            end
        end else begin
            rng_vram  = lcg_step(rng_vram);
            vram_wait = rng_vram[17:16];
        end
    end

    always @(negedge clk) begin
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs) begin
            if (rom_wait == 2'd0) begin
                rom_ok   = 1'b1;
                rom_data = rom_mem[rom_addr];
            end else begin
                rom_wait = rom_wait - 2'd1;
            end
        end else begin
            rng_rom  = lcg_step(rng_rom);
            rom_wait = rng_rom[19:18];
        end
    end

    // Compares values sampled just before each pixel clock edge
    always @(posedge clk) begin
        video_pkg::rgb_t act_c;
        int              nh;
        int              nv;
        if (reset) begin
            hist_n = 0;
        end else if (pxl_cen) begin
            check_bit("hs", hdump >= `HS_START && hdump < `HS_END, hs);
            check_bit("vs", vdump >= `VS_START && vdump < `VS_END, vs);
            check_bit("hb", hdump >= `H_VISIBLE, hb);
            check_bit("vb", vdump >= `V_VISIBLE, vb);
            if (hist_n > 0) begin
                nh = (h1 == `H_TOTAL - 1) ? 0 : h1 + 1;
                nv = (h1 != `H_TOTAL - 1) ? v1 : (v1 == `V_TOTAL - 1) ? 0 : v1 + 1;
                check_word("hdump step", 16'(nh), {7'd0, hdump});
                check_word("vdump step", 16'(nv), {7'd0, vdump});
            end
            if (hdump == 9'd0) begin
                nv = (vdump == `V_TOTAL - 1) ? 0 : int'(vdump) + 1;
                sh_hpos[nv] = m_reg[0];
                sh_vpos[nv] = m_reg[1];
                sh_base[nv] = m_reg[2];
            end
            if (hist_n >= 2 && check_on) begin
                act_c = '{r: red[7:4], g: green[7:4], b: blue[7:4]};
                check_rgb(test_name, expected_rgb(h2, v2), act_c);
                check_bit("lhbl_dly", h2 < `H_VISIBLE, lhbl_dly);
                check_bit("lvbl_dly", v2 < `V_VISIBLE, lvbl_dly);
                if (red[3:0] !== red[7:4] || green[3:0] !== green[7:4] ||
                    blue[3:0] !== blue[7:4]) begin
                    other_errs++;
                    $display("colour outputs do not repeat their upper nibble at %0t", $time);
                end
            end
            h2 = h1;
            v2 = v1;
            h1 = hdump;
            v1 = vdump;
            if (hist_n < 2) hist_n++;
        end
    end

    initial begin
        #(RUN_FRAMES * FRAME_NS + 20000);
        $display("timeout: the run did not complete in the expected time");
        $display("test failed");
        $finish;
    end

    initial begin
        logic [15:0] d;
        reset = 1'b1;
        pxl_cen = 1'b0;
        cen_cnt = 2'd0;
        cpu_cs = 1'b0;
        addr = 4'd0;
        dsn = 2'b11;
        cpu_dout = 16'd0;
        vram_data = 16'd0;
        vram_ok = 1'b0;
        rom_data = 32'd0;
        rom_ok = 1'b0;
        vram_wait = 2'd0;
        rom_wait = 2'd0;
        check_on = 1'b0;
        hist_n = 0;
        rgb_errs = 0;
        word_errs = 0;
        bit_errs = 0;
        other_errs = 0;
        rng_main = 32'd68341;
        rng_vram = lcg_step(32'd68341 + 32'd1);
        rng_rom  = lcg_step(32'd68341 + 32'd2);
        for (int i = 0; i < 7; i++) m_reg[i] = '0;
        for (int i = 0; i < 64; i++) m_pal[i] = '0;
        for (int i = 0; i < 262144; i++) begin
            rng_main = lcg_step(rng_main);
            map_mem[i] = rng_main[31:16];
        end
        for (int i = 0; i < 32768; i++) begin
            rng_main = lcg_step(rng_main);
            rom_mem[i][31:16] = rng_main[31:16];
            rng_main = lcg_step(rng_main);
            rom_mem[i][15:0] = rng_main[31:16];
        end

        test_name = "reset";
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_bit("reset vram_cs", 1'b0, vram_cs);
        check_bit("reset rom_cs", 1'b0, rom_cs);
        check_bit("reset hs", 1'b0, hs);
        check_bit("reset vs", 1'b0, vs);
        for (int a = 0; a < 7; a++) begin
            addr = a[3:0];
            #0.2;
            check_word("reset mmr_dout", 16'd0, mmr_dout);
        end

        test_name = "regs";
        cpu_write(0, 16'hffff, 2'b00);
        read_check(0, "hpos full");
        cpu_write(0, 16'h0012, 2'b10);
        read_check(0, "hpos low lane");
        cpu_write(0, 16'h0100, 2'b01);
        read_check(0, "hpos high lane");
        for (int a = 0; a < 7; a++) begin
            repeat (3) begin
                rng_main = lcg_step(rng_main);
                cpu_write(a, rng_main[31:16], rng_main[13:12]);
                read_check(a, "reg lanes");
            end
        end

        // Raster rules are checked by the compare process on every pixel
        test_name = "raster";
        wait_frame_start();
        wait_frame_start();

        test_name = "palette";
        cpu_write(5, 16'd0, 2'b00);
        for (int i = 0; i < 64; i++) begin
            rng_main = lcg_step(rng_main);
            cpu_write(6, rng_main[31:16], 2'b00);
        end
        read_check(5, "pal index wrap");
        foreach (m_reg[k]) begin
            d = 16'((k * 23 + 3) % 64);
            cpu_write(5, d, 2'b00);
            cpu_write(6, {4'd0, m_pal[d[5:0]]}, 2'b00);
            read_check(6, "pal data");
            read_check(5, "pal index step");
        end
        rng_main = lcg_step(rng_main);
        cpu_write(3, rng_main[31:16], 2'b00);
        cpu_write(4, 16'd0, 2'b00);
        test_name = "backdrop";
        wait_frame_start();
        wait_frame_start();
        check_on = 1'b1;
        wait_frame_start();
        check_on = 1'b0;

        test_name = "scroll";
        rng_main = lcg_step(rng_main);
        cpu_write(2, rng_main[31:16], 2'b00);
        rng_main = lcg_step(rng_main);
        // Low byte near 255 so the line wraps around the map
        cpu_write(0, (rng_main[31:16] & 16'h030f) | 16'h00f0, 2'b00);
        rng_main = lcg_step(rng_main);
        cpu_write(1, rng_main[31:16], 2'b00);
        cpu_write(4, 16'd1, 2'b00);
        wait_frame_start();
        wait_frame_start();
        check_on = 1'b1;
        wait_frame_start();

        test_name = "midscroll";
        do @(negedge clk); while (!(vdump == 9'd12 && hdump == 9'd20));
        cpu_write(0, m_reg[0] ^ 16'h0005, 2'b00);
        wait_frame_start();
        wait_frame_start();
        check_on = 1'b0;

        $display("errors: rgb %0d word %0d bit %0d other %0d",
                 rgb_errs, word_errs, bit_errs, other_errs);
        if (rgb_errs + word_errs + bit_errs + other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/video_mmr.sv
verilog/tile_scroll.sv
verilog/layer_mix.sv
verilog/video_top.sv
verif/video_tb.sv

// File: Makefile
# Verilator build for the tile video subsystem

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = video_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation reported failure" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
